//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := tb_top
FILELIST := sim.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int XLEN  = 32;
  localparam int NREGS = 16;
  localparam int RBITS = 4;

  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_ADDI = 4'h6,
    OP_LD   = 4'h7,
    OP_ST   = 4'h8,
    OP_BZ   = 4'h9,
    OP_HALT = 4'hf
  } opcode_e;

  // Instruction word layout with the opcode in the top nibble
  typedef struct packed {
    opcode_e          op;
    logic [RBITS-1:0] rd;
    logic [RBITS-1:0] ra;
    logic [RBITS-1:0] rb;
    logic [15:0]      imm;
  } instr_t;

  typedef struct packed {
    logic z;
    logic n;
    logic c;
  } ccr_t;

  typedef enum logic [1:0] {
    FWD_REG = 2'h0,
    FWD_MEM = 2'h1,
    FWD_EXE = 2'h2
  } fwd_e;

endpackage

`default_nettype wire

//--- execute.sv
`default_nettype none

module execute (
  input  wire                clk_i,
  input  wire                rst_i,
  input  wire                flush_i,
  input  var  cpu_pkg::fwd_e fwd_a_i,
  input  var  cpu_pkg::fwd_e fwd_b_i,
  input  wire  [31:0]        rdata_a_i,
  input  wire  [31:0]        rdata_b_i,
  input  wire  [31:0]        mem_fwd_i,
  stage_if.dst               in,
  stage_if.src               out
);

  cpu_pkg::instr_t ins;
  cpu_pkg::fwd_e   fwd_a_q;
  cpu_pkg::fwd_e   fwd_b_q;
  cpu_pkg::ccr_t   ccr_q;
  cpu_pkg::ccr_t   ccr_next;
  logic [31:0]     op_a;
  logic [31:0]     op_b;
  logic [31:0]     simm;
  logic [32:0]     alu;
  logic            is_alu;
  logic            valid_q;
  logic [31:0]     ir_q;
  logic [31:0]     pc_q;
  logic [31:0]     res_q;
  logic [31:0]     addr_q;
  logic [3:0]      rd_q;
  logic            reg_we_q;
  logic            is_load_q;

  assign ins  = cpu_pkg::instr_t'(in.ir);
  assign simm = {{16{ins.imm[15]}}, ins.imm};

  // Select is registered with the operands so it lines up with this slot
  always_comb
    begin
      case (fwd_a_q)
        cpu_pkg::FWD_EXE: op_a = res_q;
        cpu_pkg::FWD_MEM: op_a = mem_fwd_i;
        default:          op_a = rdata_a_i;
      endcase
      case (fwd_b_q)
        cpu_pkg::FWD_EXE: op_b = res_q;
        cpu_pkg::FWD_MEM: op_b = mem_fwd_i;
        default:          op_b = rdata_b_i;
      endcase
    end

  always_comb
    begin
      is_alu = 1'b1;
      case (ins.op)
        cpu_pkg::OP_ADD:  alu = {1'b0, op_a} + {1'b0, op_b};
        cpu_pkg::OP_SUB:  alu = {1'b0, op_a} - {1'b0, op_b};
        cpu_pkg::OP_AND:  alu = {1'b0, op_a & op_b};
        cpu_pkg::OP_OR:   alu = {1'b0, op_a | op_b};
        cpu_pkg::OP_XOR:  alu = {1'b0, op_a ^ op_b};
        cpu_pkg::OP_ADDI: alu = {1'b0, op_a} + {1'b0, simm};
        default:
          begin
            alu    = {1'b0, op_b}; // Store data rides in result
            is_alu = 1'b0;
          end
      endcase
      ccr_next = ccr_q;
      if (is_alu)
        ccr_next = '{z: (alu[31:0] == 32'd0), n: alu[31], c: alu[32]};
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          valid_q <= 1'b0;
          ccr_q   <= '0;
          fwd_a_q <= cpu_pkg::FWD_REG;
          fwd_b_q <= cpu_pkg::FWD_REG;
        end
      else
        begin
          valid_q <= in.valid && !flush_i;
          fwd_a_q <= fwd_a_i;
          fwd_b_q <= fwd_b_i;
          if (in.valid && !flush_i)
            ccr_q <= ccr_next; // Squashed slots leave the flags alone
        end
    end

  always_ff @(posedge clk_i)
    begin
      ir_q      <= in.ir;
      pc_q      <= in.pc;
      rd_q      <= in.rd;
      reg_we_q  <= in.reg_we;
      is_load_q <= in.is_load;
      res_q     <= alu[31:0];
      addr_q    <= (ins.op == cpu_pkg::OP_BZ) ? {simm[29:0], 2'b00} : op_a + simm;
    end

  assign out.valid   = valid_q;
  assign out.ir      = ir_q;
  assign out.pc      = pc_q;
  assign out.result  = res_q;
  assign out.addr    = addr_q;
  assign out.rd      = rd_q;
  assign out.reg_we  = reg_we_q;
  assign out.is_load = is_load_q;
  assign out.ccr     = ccr_q;

endmodule

`default_nettype wire

//--- hazard.sv
`default_nettype none

module hazard (
  stage_if.dst          dec,
  stage_if.dst          exe,
  stage_if.dst          mem,
  input  wire           mem_busy_i,
  output logic          stall_o,
  output cpu_pkg::fwd_e fwd_a_o,
  output cpu_pkg::fwd_e fwd_b_o
);

  cpu_pkg::instr_t ins;
  logic            uses_a;
  logic            uses_b;
  logic            exe_wr;
  logic            mem_wr;
  logic            load_use;

  assign ins = cpu_pkg::instr_t'(dec.ir);

  always_comb
    begin
      uses_a = 1'b1;
      uses_b = 1'b0;
      case (ins.op)
        cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
        cpu_pkg::OP_XOR, cpu_pkg::OP_ST:
          uses_b = 1'b1;
        cpu_pkg::OP_NOP, cpu_pkg::OP_BZ, cpu_pkg::OP_HALT:
          uses_a = 1'b0;
        default: ;
      endcase
    end

  assign exe_wr = exe.valid && exe.reg_we && exe.rd != 4'd0;
  assign mem_wr = mem.valid && mem.reg_we && mem.rd != 4'd0;

  // Load data is not ready until the cycle after the load leaves execute
  assign load_use = dec.valid && exe_wr && exe.is_load &&
                    ((uses_a && ins.ra == exe.rd) || (uses_b && ins.rb == exe.rd));

  assign stall_o = load_use || mem_busy_i;

  always_comb
    begin
      fwd_a_o = cpu_pkg::FWD_REG;
      fwd_b_o = cpu_pkg::FWD_REG;
      if (exe_wr && ins.ra == exe.rd)
        fwd_a_o = cpu_pkg::FWD_EXE;
      else if (mem_wr && ins.ra == mem.rd)
        fwd_a_o = cpu_pkg::FWD_MEM;
      if (exe_wr && ins.rb == exe.rd)
        fwd_b_o = cpu_pkg::FWD_EXE;
      else if (mem_wr && ins.rb == mem.rd)
        fwd_b_o = cpu_pkg::FWD_MEM;
    end

endmodule

`default_nettype wire

//--- idecode.sv
`default_nettype none

module idecode (
  input  wire         clk_i,
  input  wire         rst_i,
  input  wire         stall_i,
  input  wire         flush_i,
  input  wire         wr_en_i,
  input  wire  [3:0]  wr_rd_i,
  input  wire  [31:0] wr_data_i,
  stage_if.dst        in,
  stage_if.src        out,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o
);

  logic [31:0]     regs [cpu_pkg::NREGS];
  cpu_pkg::instr_t ins;
  logic [31:0]     rd_a;
  logic [31:0]     rd_b;
  logic            we;
  logic            valid_q;
  logic [31:0]     ir_q;
  logic [31:0]     pc_q;
  logic [3:0]      rd_q;
  logic            reg_we_q;
  logic            is_load_q;

  assign ins = cpu_pkg::instr_t'(in.ir);

  // Write-through so a same-cycle read sees the value being written
  assign rd_a = (ins.ra == 4'd0) ? 32'd0 :
                (wr_en_i && wr_rd_i == ins.ra) ? wr_data_i : regs[ins.ra];
  assign rd_b = (ins.rb == 4'd0) ? 32'd0 :
                (wr_en_i && wr_rd_i == ins.rb) ? wr_data_i : regs[ins.rb];

  always_comb
    begin
      case (ins.op)
        cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
        cpu_pkg::OP_XOR, cpu_pkg::OP_ADDI, cpu_pkg::OP_LD:
          we = 1'b1;
        default:
          we = 1'b0;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (wr_en_i && wr_rd_i != 4'd0)
        regs[wr_rd_i] <= wr_data_i; // r0 is never written
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        valid_q <= 1'b0;
      else
        valid_q <= in.valid && !stall_i && !flush_i; // Bubble on stall or flush
    end

  always_ff @(posedge clk_i)
    begin
      ir_q      <= in.ir;
      pc_q      <= in.pc;
      rd_q      <= ins.rd;
      reg_we_q  <= we;
      is_load_q <= (ins.op == cpu_pkg::OP_LD);
      rdata_a_o <= rd_a;
      rdata_b_o <= rd_b;
    end

  assign out.valid   = valid_q;
  assign out.ir      = ir_q;
  assign out.pc      = pc_q;
  assign out.rd      = rd_q;
  assign out.reg_we  = reg_we_q;
  assign out.is_load = is_load_q;
  assign out.result  = '0;
  assign out.addr    = '0;
  assign out.ccr     = '0;

endmodule

`default_nettype wire

//--- ifetch.sv
`default_nettype none

module ifetch #(
  parameter int AWIDTH = 10
) (
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire               stall_i,
  input  wire               redirect_i,
  input  wire  [31:0]       target_i,
  input  wire               ins_ack_i,
  input  wire  [31:0]       ins_dat_i,
  output logic              ins_stb_o,
  output logic [AWIDTH-1:0] ins_adr_o,
  stage_if.src              out
);

  localparam logic [31:0] PC_MASK = (32'd1 << (AWIDTH + 2)) - 32'd1;

  logic [31:0] pc_q;
  logic [31:0] fetch_pc_q;
  logic        go_q;
  logic        inflight_q;
  logic        out_valid_q;
  logic [31:0] out_ir_q;
  logic [31:0] out_pc_q;
  logic        skid_valid_q;
  logic [31:0] skid_ir_q;
  logic [31:0] skid_pc_q;
  logic        arrive;

  assign ins_stb_o = go_q && !stall_i;
  assign ins_adr_o = pc_q[AWIDTH+1:2];
  assign arrive    = ins_ack_i && inflight_q && !redirect_i; // Late words after redirect dropped

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          pc_q         <= '0;
          go_q         <= 1'b0;
          inflight_q   <= 1'b0;
          out_valid_q  <= 1'b0;
          skid_valid_q <= 1'b0;
        end
      else
        begin
          go_q       <= 1'b1;
          inflight_q <= ins_stb_o && !redirect_i;
          if (redirect_i)
            begin
              pc_q         <= target_i & PC_MASK;
              out_valid_q  <= 1'b0;
              skid_valid_q <= 1'b0;
            end
          else
            begin
              if (ins_stb_o)
                pc_q <= (pc_q + 32'd4) & PC_MASK;
              if (stall_i)
                begin
                  if (arrive)
                    skid_valid_q <= 1'b1; // Park the word while decode holds
                end
              else
                begin
                  out_valid_q  <= skid_valid_q || arrive;
                  skid_valid_q <= 1'b0;
                end
            end
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (ins_stb_o)
        fetch_pc_q <= pc_q;
      if (stall_i && arrive)
        begin
          skid_ir_q <= ins_dat_i;
          skid_pc_q <= fetch_pc_q;
        end
      if (!stall_i)
        begin
          out_ir_q <= skid_valid_q ? skid_ir_q : ins_dat_i;
          out_pc_q <= skid_valid_q ? skid_pc_q : fetch_pc_q;
        end
    end

  assign out.valid   = out_valid_q;
  assign out.ir      = out_ir_q;
  assign out.pc      = out_pc_q;
  assign out.result  = '0;
  assign out.addr    = '0;
  assign out.rd      = '0;
  assign out.reg_we  = 1'b0;
  assign out.is_load = 1'b0;
  assign out.ccr     = '0;

endmodule

`default_nettype wire

//--- mem_access.sv
`default_nettype none

module mem_access #(
  parameter int AWIDTH = 10
) (
  input  wire               clk_i,
  input  wire               rst_i,
  stage_if.dst              in,
  input  wire  [31:0]       dat_rdat_i,
  output logic              dat_stb_o,
  output logic              dat_we_o,
  output logic [AWIDTH-1:0] dat_adr_o,
  output logic [31:0]       dat_wdat_o,
  output logic              busy_o,
  output logic [31:0]       fwd_data_o,
  output logic              wr_en_o,
  output logic [3:0]        wr_rd_o,
  output logic [31:0]       wr_data_o,
  output logic              redirect_o,
  output logic [31:0]       target_o,
  output logic              flush_o,
  output logic              retire_valid_o,
  output logic [31:0]       retire_pc_o,
  output logic [3:0]        retire_rd_o,
  output logic [31:0]       retire_data_o,
  output logic              halted_o
);

  cpu_pkg::instr_t ins;
  logic            act;
  logic            wb_en_q;
  logic            ld_pend_q;
  logic [3:0]      wb_rd_q;
  logic [31:0]     wb_data_q;

  assign ins = cpu_pkg::instr_t'(in.ir);
  assign act = in.valid && !halted_o; // Nothing younger than HALT takes effect

  assign dat_stb_o  = act && (ins.op == cpu_pkg::OP_LD || ins.op == cpu_pkg::OP_ST);
  assign dat_we_o   = act && ins.op == cpu_pkg::OP_ST;
  assign dat_adr_o  = in.addr[AWIDTH+1:2];
  assign dat_wdat_o = in.result;

  assign redirect_o = act && ins.op == cpu_pkg::OP_BZ && in.ccr.z;
  assign target_o   = in.addr;
  assign flush_o    = redirect_o;

  // Read data arrives in the second cycle of a load
  assign busy_o     = ld_pend_q;
  assign wr_en_o    = wb_en_q;
  assign wr_rd_o    = wb_rd_q;
  assign wr_data_o  = ld_pend_q ? dat_rdat_i : wb_data_q;
  assign fwd_data_o = wr_data_o;

  assign retire_rd_o   = wb_en_q ? wb_rd_q : 4'd0;
  assign retire_data_o = wb_en_q ? wr_data_o : 32'd0;

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          wb_en_q        <= 1'b0;
          ld_pend_q      <= 1'b0;
          retire_valid_o <= 1'b0;
          halted_o       <= 1'b0;
        end
      else
        begin
          wb_en_q        <= act && in.reg_we && in.rd != 4'd0;
          ld_pend_q      <= act && in.is_load;
          retire_valid_o <= act;
          if (act && ins.op == cpu_pkg::OP_HALT)
            halted_o <= 1'b1;
        end
    end

  always_ff @(posedge clk_i)
    begin
      wb_rd_q     <= in.rd;
      wb_data_q   <= in.result;
      retire_pc_o <= in.pc;
    end

endmodule

`default_nettype wire

//--- program.hex
// One instruction word per line: opcode, rd, ra, rb nibbles, then a 16-bit immediate
// Data area starts at byte address 0x200, past the end of the code
61000005 // ADDI r1, r0, 5
6200FFFD // ADDI r2, r0, -3
13120000 // ADD  r3, r1, r2  forwarded from execute and memory
24310000 // SUB  r4, r3, r1
35430000 // AND  r5, r4, r3  result zero
46520000 // OR   r6, r5, r2
57610000 // XOR  r7, r6, r1
10110000 // ADD  r0, r1, r1  write to r0 is dropped
18070000 // ADD  r8, r0, r7
69000200 // ADDI r9, r0, 0x200
80970004 // ST   r7, [r9+4]
7A900004 // LD   r10, [r9+4]
1BA10000 // ADD  r11, r10, r1  load-use stall
809B0008 // ST   r11, [r9+8]
7C900008 // LD   r12, [r9+8]
6D000001 // ADDI r13, r0, 1
2ECD0000 // SUB  r14, r12, r13  load forwarded from memory
2F110000 // SUB  r15, r1, r1  zero flag set
90000016 // BZ   0x58  taken
61100064 // ADDI r1, r1, 100  squashed
62200064 // ADDI r2, r2, 100  squashed
63300064 // ADDI r3, r3, 100  squashed
6FF00007 // ADDI r15, r15, 7  zero flag clear
90000013 // BZ   0x4C  not taken
75900004 // LD   r5, [r9+4]
8095000C // ST   r5, [r9+12]  store data from a load
7690000C // LD   r6, [r9+12]
57660000 // XOR  r7, r6, r6  both operands from a load
9000001E // BZ   0x78  taken
67700001 // ADDI r7, r7, 1  squashed
00000000 // NOP
F0000000 // HALT
00000000 // NOP padding behind HALT
00000000
00000000
00000000

//--- ram2.sv
`default_nettype none

module ram2 #(
  parameter int AWIDTH = 10
) (
  input  wire               clk_i,
  input  wire               ins_stb_i,
  input  wire  [AWIDTH-1:0] ins_adr_i,
  output logic [31:0]       ins_dat_o,
  output logic              ins_ack_o,
  input  wire               dat_stb_i,
  input  wire               dat_we_i,
  input  wire  [AWIDTH-1:0] dat_adr_i,
  input  wire  [31:0]       dat_wdat_i,
  output logic [31:0]       dat_rdat_o
);

  logic [31:0] mem [2**AWIDTH];

  initial
    begin
      $readmemh("program.hex", mem);
    end

  always_ff @(posedge clk_i)
    begin
      ins_ack_o <= ins_stb_i; // Fixed one-cycle answer
      if (ins_stb_i)
        ins_dat_o <= mem[ins_adr_i];
    end

  always_ff @(posedge clk_i)
    begin
      if (dat_stb_i)
        begin
          if (dat_we_i)
            mem[dat_adr_i] <= dat_wdat_i;
          dat_rdat_o <= mem[dat_adr_i]; // Read-before-write on this port
        end
    end

endmodule

`default_nettype wire

//--- sim.f
cpu_pkg.sv
stage_if.sv
ifetch.sv
idecode.sv
execute.sv
hazard.sv
mem_access.sv
ram2.sv
top.sv
tb_top.sv

//--- stage_if.sv
`default_nettype none

interface stage_if;

  logic                           valid;
  logic [cpu_pkg::XLEN-1:0]       ir;
  logic [cpu_pkg::XLEN-1:0]       pc;
  logic [cpu_pkg::XLEN-1:0]       result; // ALU result or store data
  logic [cpu_pkg::XLEN-1:0]       addr;
  logic [cpu_pkg::RBITS-1:0]      rd;
  logic                           reg_we;
  logic                           is_load;
  cpu_pkg::ccr_t                  ccr;

  modport src (
    output valid, ir, pc, result, addr, rd, reg_we, is_load, ccr
  );

  modport dst (
    input valid, ir, pc, result, addr, rd, reg_we, is_load, ccr
  );

endinterface

`default_nettype wire

//--- tb_top.sv
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int AWIDTH       = 10;
  localparam int RESET_CYCLES = 16;
  localparam int QUIET_CYCLES = 20;
  localparam int MAX_CYCLES   = 2000; // About 32 words with stalls finish within a few hundred

  logic        clk;
  logic        rst;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic [3:0]  retire_rd;
  logic [31:0] retire_data;
  logic        halted;

  logic [31:0] ref_mem [2**AWIDTH];
  logic [31:0] ref_regs [16];
  logic [31:0] ref_pc;
  logic        ref_z;
  logic        halt_seen;
  int          cycles;
  int          retired;
  int          checks;
  logic [31:0] exp_pc;
  logic [3:0]  exp_rd;
  logic [31:0] exp_data;
  logic        exp_halt;

  top #(.AWIDTH(AWIDTH)) DUT (
    .clk_i(clk),
    .rst_i(rst),
    .retire_valid_o(retire_valid),
    .retire_pc_o(retire_pc),
    .retire_rd_o(retire_rd),
    .retire_data_o(retire_data),
    .halted_o(halted)
  );

  task automatic stop_on_failure(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
    stop_on_failure($sformatf("CHECK FAILED at %0d ns: %s is %h, expected %h",
                              $time, what, got, want));
  endtask

  // Executes one instruction of the reference model and returns what should retire
  task automatic step_reference(output logic [31:0] pc, output logic [3:0] rd_out,
                                output logic [31:0] data, output logic halt);
    logic [31:0] word;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [31:0] simm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [31:0] addr;
    logic [31:0] next_pc;
    logic        wr;
    logic        alu;
    word    = ref_mem[ref_pc[AWIDTH+1:2]];
    op      = word[31:28];
    rd      = word[27:24];
    a       = ref_regs[word[23:20]];
    b       = ref_regs[word[19:16]];
    simm    = {{16{word[15]}}, word[15:0]};
    addr    = a + simm;
    next_pc = ref_pc + 32'd4;
    value   = 32'd0;
    wr      = 1'b0;
    alu     = 1'b1;
    halt    = 1'b0;
    case (op)
      cpu_pkg::OP_ADD:  value = a + b;
      cpu_pkg::OP_SUB:  value = a - b;
      cpu_pkg::OP_AND:  value = a & b;
      cpu_pkg::OP_OR:   value = a | b;
      cpu_pkg::OP_XOR:  value = a ^ b;
      cpu_pkg::OP_ADDI: value = addr;
      default:          alu = 1'b0;
    endcase
    wr = alu;
    case (op)
      cpu_pkg::OP_LD:
        begin
          value = ref_mem[addr[AWIDTH+1:2]];
          wr    = 1'b1;
        end
      cpu_pkg::OP_ST:   ref_mem[addr[AWIDTH+1:2]] = b;
      cpu_pkg::OP_BZ:
        begin
          if (ref_z)
            next_pc = simm << 2; // Absolute word target
        end
      cpu_pkg::OP_HALT: halt = 1'b1;
      default: ;
    endcase
    if (alu)
      ref_z = (value == 32'd0);
    pc     = ref_pc;
    rd_out = 4'd0;
    data   = 32'd0;
    if (wr && rd != 4'd0)
      begin
        ref_regs[rd] = value;
        rd_out       = rd;
        data         = value;
      end
    ref_pc = next_pc & ((32'd1 << (AWIDTH + 2)) - 32'd1);
  endtask

  initial
    begin
      clk = 1'b0;
      forever #10 clk = ~clk;
    end

  always @(posedge clk)
    begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
        stop_on_failure($sformatf("Timeout: HALT did not retire within %0d cycles", MAX_CYCLES));
    end

  // Retire outputs are registered on the rising edge, so they are sampled on the falling one
  always @(negedge clk)
    begin
      if (!rst && retire_valid)
        begin
          assert (!halt_seen)
            else stop_on_failure("An instruction retired after HALT");
          retired = retired + 1;
          step_reference(exp_pc, exp_rd, exp_data, exp_halt);
          assert (retire_pc === exp_pc)
            checks = checks + 1;
          else
            report_mismatch("retire_pc_o", retire_pc, exp_pc);
          assert (retire_rd === exp_rd)
            else report_mismatch("retire_rd_o", {28'd0, retire_rd}, {28'd0, exp_rd});
          assert (retire_data === exp_data)
            else report_mismatch("retire_data_o", retire_data, exp_data);
          assert (halted === exp_halt)
            else report_mismatch("halted_o", {31'd0, halted}, {31'd0, exp_halt});
          if (exp_halt)
            halt_seen = 1'b1;
        end
      else if (!rst && !halt_seen)
        begin
          assert (halted === 1'b0)
            else stop_on_failure("halted_o rose without a HALT retiring");
        end
    end

  initial
    begin
      rst       = 1'b1;
      cycles    = 0;
      retired   = 0;
      checks    = 0;
      ref_pc    = 32'd0;
      ref_z     = 1'b0;
      halt_seen = 1'b0;
      for (int i = 0; i < 16; i++)
        ref_regs[i] = 32'd0;
      $readmemh("program.hex", ref_mem); // Same image the DUT memory starts from
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst = 1'b0;
      while (!halt_seen)
        @(posedge clk);
      repeat (QUIET_CYCLES) @(posedge clk); // Nothing may retire after HALT
      if (checks == retired)
        begin
          $display("Simulation finished: PASS");
          $finish;
        end
      else
        stop_on_failure("Retire checks did not run for every retired instruction");
    end

endmodule

`default_nettype wire

//--- top.sv
`default_nettype none

module top #(
  parameter int AWIDTH = 10
) (
  input  wire         clk_i,
  input  wire         rst_i,
  output logic        retire_valid_o,
  output logic [31:0] retire_pc_o,
  output logic [3:0]  retire_rd_o,
  output logic [31:0] retire_data_o,
  output logic        halted_o
);

  logic              stall;
  logic              busy;
  logic              redirect;
  logic              flush;
  logic [31:0]       target;
  cpu_pkg::fwd_e     fwd_a;
  cpu_pkg::fwd_e     fwd_b;
  logic [31:0]       rdata_a;
  logic [31:0]       rdata_b;
  logic [31:0]       mem_fwd;
  logic              wr_en;
  logic [3:0]        wr_rd;
  logic [31:0]       wr_data;
  logic              ins_stb;
  logic              ins_ack;
  logic [AWIDTH-1:0] ins_adr;
  logic [31:0]       ins_dat;
  logic              dat_stb;
  logic              dat_we;
  logic [AWIDTH-1:0] dat_adr;
  logic [31:0]       dat_wdat;
  logic [31:0]       dat_rdat;

  stage_if f2d ();
  stage_if d2e ();
  stage_if e2m ();

  ifetch #(.AWIDTH(AWIDTH)) fetch0 (
    .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall),
    .redirect_i(redirect), .target_i(target),
    .ins_ack_i(ins_ack), .ins_dat_i(ins_dat),
    .ins_stb_o(ins_stb), .ins_adr_o(ins_adr), .out(f2d));

  idecode decode0 (
    .clk_i(clk_i), .rst_i(rst_i), .stall_i(stall), .flush_i(flush),
    .wr_en_i(wr_en), .wr_rd_i(wr_rd), .wr_data_i(wr_data),
    .in(f2d), .out(d2e), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b));

  execute exe0 (
    .clk_i(clk_i), .rst_i(rst_i), .flush_i(flush),
    .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
    .rdata_a_i(rdata_a), .rdata_b_i(rdata_b), .mem_fwd_i(mem_fwd),
    .in(d2e), .out(e2m));

  hazard hazard0 (
    .dec(f2d), .exe(d2e), .mem(e2m), .mem_busy_i(busy),
    .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b));

  mem_access #(.AWIDTH(AWIDTH)) mem0 (
    .clk_i(clk_i), .rst_i(rst_i), .in(e2m),
    .dat_rdat_i(dat_rdat), .dat_stb_o(dat_stb), .dat_we_o(dat_we),
    .dat_adr_o(dat_adr), .dat_wdat_o(dat_wdat),
    .busy_o(busy), .fwd_data_o(mem_fwd),
    .wr_en_o(wr_en), .wr_rd_o(wr_rd), .wr_data_o(wr_data),
    .redirect_o(redirect), .target_o(target), .flush_o(flush),
    .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
    .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
    .halted_o(halted_o));

  ram2 #(.AWIDTH(AWIDTH)) ram0 (
    .clk_i(clk_i),
    .ins_stb_i(ins_stb), .ins_adr_i(ins_adr),
    .ins_dat_o(ins_dat), .ins_ack_o(ins_ack),
    .dat_stb_i(dat_stb), .dat_we_i(dat_we), .dat_adr_i(dat_adr),
    .dat_wdat_i(dat_wdat), .dat_rdat_o(dat_rdat));

endmodule

`default_nettype wire
